//--- hdl/tqv_bus_pkg.sv
package tqv_bus_pkg;

    localparam int addr_w = 11;
    localparam int data_w = 32;

    // Active-low access size as driven by the core, 3 means no access
    typedef enum logic [1:0] {acc_8 = 2'b00, acc_16 = 2'b01, acc_32 = 2'b10, acc_idle = 2'b11} access_n_t;

    // User region: 16 slots of 64 bytes, bit 10 clear
    typedef struct packed {
        logic       simple;
        logic [3:0] slot;
        logic [5:0] offset;
    } user_addr_t;

    // Simple region: 16 slots of 16 bytes, bit 10 set
    typedef struct packed {
        logic       simple;
        logic [1:0] unused;
        logic [3:0] slot;
        logic [3:0] offset;
    } simple_addr_t;

    // Same address word, decoded by whichever region bit 10 selects
    typedef union packed {
        user_addr_t   user;
        simple_addr_t simple;
    } peri_addr_t;

endpackage

//--- hdl/tqv_periph_pkg.sv
package tqv_periph_pkg;

    // Slot count of each region
    localparam int num_slots = 16;

    // Populated slots
    localparam logic [3:0] slot_gpio = 4'd1;
    localparam logic [3:0] slot_word_regs = 4'd4;
    localparam logic [3:0] slot_byte_regs = 4'd0;

    // GPIO register map
    localparam logic [5:0] gpio_out_off = 6'd0;
    localparam logic [5:0] gpio_in_off = 6'd4;
    // Function selects at base + 4 * pin
    localparam logic [5:0] gpio_sel_base = 6'd32;

    localparam int pins = 8;

    // Output source of one pin, simple set means simple region
    typedef struct packed {
        logic       simple;
        logic [3:0] slot;
    } func_sel_t;

    // All pins driven by the GPIO output register after reset
    localparam func_sel_t func_sel_reset = '{simple: 1'b0, slot: slot_gpio};

endpackage

//--- hdl/peri_bus_if.sv
`timescale 1ns/10ps

// Word-wide access port of one user-region peripheral
interface peri_bus_if;

    logic [5:0]                      offset;
    logic [tqv_bus_pkg::data_w-1:0]  wdata;
    tqv_bus_pkg::access_n_t          write_n;
    tqv_bus_pkg::access_n_t          read_n;
    logic [tqv_bus_pkg::data_w-1:0]  rdata;
    logic                            ready;

    modport host (
        output offset,
        output wdata,
        output write_n,
        output read_n,
        input  rdata,
        input  ready
    );

    modport dev (
        input  offset,
        input  wdata,
        input  write_n,
        input  read_n,
        output rdata,
        output ready
    );

endinterface

//--- hdl/byte_bus_if.sv
`timescale 1ns/10ps

// Byte-wide access port of one simple-region peripheral, always ready
interface byte_bus_if;

    logic [3:0] offset;
    logic       write;
    logic [7:0] wdata;
    logic [7:0] rdata;

    modport host (
        output offset,
        output write,
        output wdata,
        input  rdata
    );

    modport dev (
        input  offset,
        input  write,
        input  wdata,
        output rdata
    );

endinterface

//--- hdl/tqv_bus_bridge.sv
`timescale 1ns/10ps

module tqv_bus_bridge (
    input  logic                            clk,
    input  logic                            rst_n,
    input  tqv_bus_pkg::peri_addr_t         i_addr,
    input  logic [tqv_bus_pkg::data_w-1:0]  i_wdata,
    input  tqv_bus_pkg::access_n_t          i_write_n,
    input  tqv_bus_pkg::access_n_t          i_read_n,
    input  logic                            i_read_complete,
    output logic [tqv_bus_pkg::data_w-1:0]  o_rdata,
    output logic                            o_ready,
    peri_bus_if.host                        gpio_bus,
    peri_bus_if.host                        word_bus,
    byte_bus_if.host                        byte_bus
);

    logic                           ready_r;
    logic                           rdata_hold;
    logic [tqv_bus_pkg::data_w-1:0] rdata_r;
    logic                           read_req;
    logic                           write_req;
    tqv_bus_pkg::access_n_t         read_n_peri;
    logic                           gpio_sel;
    logic                           word_sel;
    logic                           byte_sel;
    logic [tqv_bus_pkg::data_w-1:0] peri_rdata;
    logic                           peri_ready;

    assign read_req  = i_read_n != tqv_bus_pkg::acc_idle;
    assign write_req = i_write_n != tqv_bus_pkg::acc_idle;

    // No second read reaches a peripheral while the captured result is presented
    assign read_n_peri = tqv_bus_pkg::access_n_t'(i_read_n | {2{ready_r}});

    // Slot select, using the address view of the region bit
    assign gpio_sel = !i_addr.user.simple && i_addr.user.slot == tqv_periph_pkg::slot_gpio;
    assign word_sel = !i_addr.user.simple && i_addr.user.slot == tqv_periph_pkg::slot_word_regs;
    assign byte_sel = i_addr.simple.simple &&
                      i_addr.simple.slot == tqv_periph_pkg::slot_byte_regs;

    assign gpio_bus.offset  = i_addr.user.offset;
    assign gpio_bus.wdata   = i_wdata;
    assign gpio_bus.write_n = gpio_sel ? i_write_n : tqv_bus_pkg::acc_idle;
    assign gpio_bus.read_n  = gpio_sel ? read_n_peri : tqv_bus_pkg::acc_idle;

    assign word_bus.offset  = i_addr.user.offset;
    assign word_bus.wdata   = i_wdata;
    assign word_bus.write_n = word_sel ? i_write_n : tqv_bus_pkg::acc_idle;
    assign word_bus.read_n  = word_sel ? read_n_peri : tqv_bus_pkg::acc_idle;

    assign byte_bus.offset = i_addr.simple.offset;
    assign byte_bus.write  = write_req && byte_sel;
    assign byte_bus.wdata  = i_wdata[7:0];

    // Response of the addressed slot; empty slots answer zero at once
    always_comb begin
        peri_rdata = '0;
        peri_ready = 1'b1;
        if (byte_sel) begin
            peri_rdata = {24'h0, byte_bus.rdata};
        end else if (gpio_sel) begin
            peri_rdata = gpio_bus.rdata;
            peri_ready = gpio_bus.ready;
        end else if (word_sel) begin
            peri_rdata = word_bus.rdata;
            peri_ready = word_bus.ready;
        end
    end

    // Capture read data and keep it until the core has taken it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata_hold <= 1'b0;
            ready_r    <= 1'b0;
        end else begin
            if (i_read_complete) begin
                rdata_hold <= 1'b0;
            end
            if (!rdata_hold && peri_ready && read_req) begin
                rdata_hold <= 1'b1;
                rdata_r    <= peri_rdata;
            end
            ready_r <= read_req && peri_ready;
        end
    end

    assign o_rdata = rdata_r;
    // Writes complete in the cycle they are presented
    assign o_ready = ready_r || write_req;

endmodule

//--- hdl/tqv_gpio.sv
`timescale 1ns/10ps

module tqv_gpio (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [7:0]                                    i_ui_in,
    peri_bus_if.dev                                       bus,
    output logic [7:0]                                    o_gpio_out,
    output tqv_periph_pkg::func_sel_t [tqv_periph_pkg::pins-1:0] o_func_sel
);

    logic       wr_en;
    logic       out_hit;
    logic       in_hit;
    logic       sel_hit;
    logic [2:0] sel_idx;

    assign wr_en   = bus.write_n != tqv_bus_pkg::acc_idle;
    assign out_hit = bus.offset == tqv_periph_pkg::gpio_out_off;
    assign in_hit  = bus.offset == tqv_periph_pkg::gpio_in_off;

    // Selects sit on word boundaries from the base, bits 4..2 name the pin
    assign sel_hit = (bus.offset & ~6'h1c) == tqv_periph_pkg::gpio_sel_base;
    assign sel_idx = bus.offset[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_gpio_out <= '0;
        end else if (wr_en && out_hit) begin
            o_gpio_out <= bus.wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_func_sel <= {tqv_periph_pkg::pins{tqv_periph_pkg::func_sel_reset}};
        end else if (wr_en && sel_hit) begin
            o_func_sel[sel_idx] <= tqv_periph_pkg::func_sel_t'(bus.wdata[4:0]);
        end
    end

    always_comb begin
        bus.rdata = '0;
        if (out_hit) begin
            bus.rdata = {24'h0, o_gpio_out};
        end else if (in_hit) begin
            bus.rdata = {24'h0, i_ui_in};
        end else if (sel_hit) begin
            bus.rdata = {27'h0, o_func_sel[sel_idx]};
        end
    end

    // Reads answer in the same cycle
    assign bus.ready = bus.read_n != tqv_bus_pkg::acc_idle;

endmodule

//--- hdl/tqv_pin_mux.sv
`timescale 1ns/10ps

module tqv_pin_mux (
    input  tqv_periph_pkg::func_sel_t [tqv_periph_pkg::pins-1:0] i_func_sel,
    input  logic [7:0]                                    i_gpio_out,
    input  logic [7:0]                                    i_word_out,
    input  logic [7:0]                                    i_byte_out,
    output logic [7:0]                                    o_uo_out
);

    logic [7:0] user_out   [tqv_periph_pkg::num_slots];
    logic [7:0] simple_out [tqv_periph_pkg::num_slots];

    // Slot output tables, empty slots drive zero
    always_comb begin
        for (int s = 0; s < tqv_periph_pkg::num_slots; s++) begin
            user_out[s]   = '0;
            simple_out[s] = '0;
        end
        user_out[tqv_periph_pkg::slot_gpio]        = i_gpio_out;
        user_out[tqv_periph_pkg::slot_word_regs]   = i_word_out;
        simple_out[tqv_periph_pkg::slot_byte_regs] = i_byte_out;
    end

    // Pin n takes bit n of the slot its select names
    always_comb begin
        for (int n = 0; n < tqv_periph_pkg::pins; n++) begin
            if (i_func_sel[n].simple) begin
                o_uo_out[n] = simple_out[i_func_sel[n].slot][n];
            end else begin
                o_uo_out[n] = user_out[i_func_sel[n].slot][n];
            end
        end
    end

endmodule

//--- hdl/tqv_word_regs.sv
`timescale 1ns/10ps

module tqv_word_regs (
    input  logic       clk,
    input  logic       rst_n,
    peri_bus_if.dev    bus,
    output logic [7:0] o_uo_out,
    output logic       o_interrupt
);

    logic [31:0] reg0;
    logic [31:0] reg1;
    logic        wr_en;

    // Only the low 1, 2 or 4 bytes of a write are valid
    function automatic logic [31:0] merge(input logic [31:0] old_v,
                                          input logic [31:0] new_v,
                                          input tqv_bus_pkg::access_n_t size);
        logic [31:0] mask;
        case (size)
            tqv_bus_pkg::acc_8:  mask = 32'h0000_00ff;
            tqv_bus_pkg::acc_16: mask = 32'h0000_ffff;
            default:             mask = 32'hffff_ffff;
        endcase
        return (old_v & ~mask) | (new_v & mask);
    endfunction

    assign wr_en = bus.write_n != tqv_bus_pkg::acc_idle;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg0        <= '0;
            reg1        <= '0;
            o_interrupt <= 1'b0;
        end else if (wr_en) begin
            case (bus.offset)
                6'h00:   reg0 <= merge(reg0, bus.wdata, bus.write_n);
                6'h04:   reg1 <= merge(reg1, bus.wdata, bus.write_n);
                6'h08:   o_interrupt <= bus.wdata[0];
                default: ;
            endcase
        end
    end

    always_comb begin
        case (bus.offset)
            6'h00:   bus.rdata = reg0;
            6'h04:   bus.rdata = reg1;
            6'h08:   bus.rdata = {31'h0, o_interrupt};
            default: bus.rdata = '0;
        endcase
    end

    assign bus.ready = bus.read_n != tqv_bus_pkg::acc_idle;
    assign o_uo_out  = reg0[7:0];

endmodule

//--- hdl/tqv_byte_regs.sv
`timescale 1ns/10ps

module tqv_byte_regs (
    input  logic       clk,
    input  logic       rst_n,
    byte_bus_if.dev    bus,
    output logic [7:0] o_uo_out
);

    logic [7:0] regs [4];
    logic       in_range;

    // Four bytes at offsets 0..3, the rest of the slot is empty
    assign in_range = bus.offset[3:2] == 2'b00;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (bus.write && in_range) begin
            regs[bus.offset[1:0]] <= bus.wdata;
        end
    end

    assign bus.rdata = in_range ? regs[bus.offset[1:0]] : 8'h00;

    // Pins show a combination of two registers
    assign o_uo_out = regs[0] ^ regs[1];

endmodule

//--- hdl/tqv_peripherals.sv
`timescale 1ns/10ps

module tqv_peripherals (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [7:0]                       i_ui_in,
    input  logic [tqv_bus_pkg::addr_w-1:0]   i_addr,
    input  logic [tqv_bus_pkg::data_w-1:0]   i_wdata,
    input  logic [1:0]                       i_write_n,
    input  logic [1:0]                       i_read_n,
    input  logic                             i_read_complete,
    output logic [tqv_bus_pkg::data_w-1:0]   o_rdata,
    output logic                             o_ready,
    output logic [7:0]                       o_uo_out,
    output logic [15:2]                      o_user_interrupts
);

    peri_bus_if gpio_bus ();
    peri_bus_if word_bus ();
    byte_bus_if byte_bus ();

    tqv_periph_pkg::func_sel_t [tqv_periph_pkg::pins-1:0] func_sel;

    logic [7:0] gpio_out;
    logic [7:0] word_out;
    logic [7:0] byte_out;
    logic       word_irq;

    tqv_bus_bridge u_bridge (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_addr          (tqv_bus_pkg::peri_addr_t'(i_addr)),
        .i_wdata         (i_wdata),
        .i_write_n       (tqv_bus_pkg::access_n_t'(i_write_n)),
        .i_read_n        (tqv_bus_pkg::access_n_t'(i_read_n)),
        .i_read_complete (i_read_complete),
        .o_rdata         (o_rdata),
        .o_ready         (o_ready),
        .gpio_bus        (gpio_bus.host),
        .word_bus        (word_bus.host),
        .byte_bus        (byte_bus.host)
    );

    tqv_gpio u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_ui_in    (i_ui_in),
        .bus        (gpio_bus.dev),
        .o_gpio_out (gpio_out),
        .o_func_sel (func_sel)
    );

    tqv_word_regs u_word_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus         (word_bus.dev),
        .o_uo_out    (word_out),
        .o_interrupt (word_irq)
    );

    tqv_byte_regs u_byte_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus      (byte_bus.dev),
        .o_uo_out (byte_out)
    );

    tqv_pin_mux u_pin_mux (
        .i_func_sel (func_sel),
        .i_gpio_out (gpio_out),
        .i_word_out (word_out),
        .i_byte_out (byte_out),
        .o_uo_out   (o_uo_out)
    );

    // Each user slot owns the interrupt line of its own number
    always_comb begin
        o_user_interrupts = '0;
        o_user_interrupts[tqv_periph_pkg::slot_word_regs] = word_irq;
    end

endmodule

//--- tb/tqv_peripherals_props.sv
`timescale 1ns/10ps

// Read handshake checks on the bus bridge
module tqv_peripherals_props (
    input logic        clk,
    input logic        rst_n,
    input logic        i_read_req,
    input logic        i_ready_r,
    input logic        i_rdata_hold,
    input logic        i_read_complete,
    input logic [31:0] i_rdata
);

    // A new read is answered exactly one cycle later
    read_ready_delay: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_read_req) |-> !i_ready_r ##1 i_ready_r)
        else $error("o_ready did not rise exactly one cycle after a read request");

    // Captured data stays put until the core takes it
    rdata_held: assert property (@(posedge clk) disable iff (!rst_n)
        i_rdata_hold && !i_read_complete |=> $stable(i_rdata))
        else $error("o_rdata changed while the read data was held");

    ready_after_reset: assert property (@(posedge clk) !rst_n |=> !i_ready_r)
        else $error("o_ready was high right after reset");

endmodule

bind tqv_bus_bridge tqv_peripherals_props u_props (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_read_req      (read_req),
    .i_ready_r       (ready_r),
    .i_rdata_hold    (rdata_hold),
    .i_read_complete (i_read_complete),
    .i_rdata         (o_rdata)
);

//--- tb/tb_tqv_peripherals.sv
`timescale 1ns/10ps

module tb_tqv_peripherals;

    localparam int period = 8;
    localparam int n_loop = 12;
    localparam int n_route = 6;
    // Bus operations over all tests, each one bounded by 20 cycles
    localparam int num_ops = 9 * n_loop + 21 * n_route + 70;
    localparam int wd_cycles = num_ops * 20 + 60;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [7:0]  i_ui_in;
    logic [10:0] i_addr;
    logic [31:0] i_wdata;
    logic [1:0]  i_write_n;
    logic [1:0]  i_read_n;
    logic        i_read_complete;
    logic [31:0] o_rdata;
    logic        o_ready;
    logic [7:0]  o_uo_out;
    logic [15:2] o_user_interrupts;

    // Register model of the populated slots
    logic [7:0]  m_gpio;
    logic [4:0]  m_sel [8];
    logic [31:0] m_word [2];
    logic        m_irq;
    logic [7:0]  m_byte [4];
    logic [7:0]  m_ui;

    logic [31:0] seed = 32'hc2892d61;
    int          errors = 0;
    int          checks = 0;
    string       name_q [$];
    logic [31:0] exp_q [$];
    logic [31:0] act_q [$];
    string       c_name;
    logic [31:0] c_exp;
    logic [31:0] c_act;

    tqv_peripherals dut (.*);

    always #(period / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [10:0] user_addr(input logic [3:0] slot, input logic [5:0] off);
        return {1'b0, slot, off};
    endfunction

    function automatic logic [10:0] simple_addr(input logic [3:0] slot, input logic [3:0] off);
        return {1'b1, 2'b00, slot, off};
    endfunction

    // Function select of a pin sits at base + 4 * pin
    function automatic logic [10:0] sel_addr(input logic [2:0] pin);
        return user_addr(tqv_periph_pkg::slot_gpio,
                         tqv_periph_pkg::gpio_sel_base + {1'b0, pin, 2'b00});
    endfunction

    function automatic logic [31:0] ref_read(input logic [10:0] addr);
        logic [5:0]  off;
        logic [31:0] val;
        val = '0;
        off = addr[10] ? {2'b00, addr[3:0]} : addr[5:0];
        if (!addr[10] && addr[9:6] == tqv_periph_pkg::slot_gpio) begin
            if (off == tqv_periph_pkg::gpio_out_off) val = {24'h0, m_gpio};
            else if (off == tqv_periph_pkg::gpio_in_off) val = {24'h0, m_ui};
            else if (off >= 6'd32 && off[1:0] == 2'b00) val = {27'h0, m_sel[off[4:2]]};
        end else if (!addr[10] && addr[9:6] == tqv_periph_pkg::slot_word_regs) begin
            case (off)
                6'd0:    val = m_word[0];
                6'd4:    val = m_word[1];
                6'd8:    val = {31'h0, m_irq};
                default: val = '0;
            endcase
        end else if (addr[10] && addr[7:4] == tqv_periph_pkg::slot_byte_regs && off < 6'd4) begin
            val = {24'h0, m_byte[off[1:0]]};
        end
        return val;
    endfunction

    function automatic logic [7:0] ref_pins();
        logic [7:0] src;
        logic [7:0] pins;
        for (int n = 0; n < 8; n++) begin
            // User slot 1 GPIO, user slot 4 word regs, simple slot 0 byte regs
            case (m_sel[n])
                5'h01:   src = m_gpio;
                5'h04:   src = m_word[0][7:0];
                5'h10:   src = m_byte[0] ^ m_byte[1];
                default: src = 8'h00;
            endcase
            pins[n] = src[n];
        end
        return pins;
    endfunction

    task automatic record(input string name, input logic [31:0] exp, input logic [31:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    // o_ready is sampled on the falling edge, at most 16 cycles
    task automatic wait_ready(input string name, output logic ok);
        int n;
        n = 0;
        @(negedge clk);
        while (!o_ready && n < 16) begin
            @(negedge clk);
            n++;
        end
        ok = o_ready;
        if (!ok) begin
            errors++;
            $display("%s: o_ready never rose after the request", name);
        end
    endtask

    task automatic bus_write(input logic [10:0] addr, input logic [31:0] data,
                             input logic [1:0] size);
        logic        ok;
        logic [31:0] mask;
        @(posedge clk);
        i_addr    <= addr;
        i_wdata   <= data;
        i_write_n <= size;
        wait_ready("write", ok);
        @(posedge clk);
        i_write_n <= 2'b11;
        mask = size == 2'b00 ? 32'h0000_00ff : size == 2'b01 ? 32'h0000_ffff : 32'hffff_ffff;
        if (!addr[10] && addr[9:6] == tqv_periph_pkg::slot_gpio) begin
            if (addr[5:0] == 6'd0) m_gpio = data[7:0];
            else if (addr[5:0] >= 6'd32 && addr[1:0] == 2'b00) m_sel[addr[4:2]] = data[4:0];
        end else if (!addr[10] && addr[9:6] == tqv_periph_pkg::slot_word_regs) begin
            if (addr[5:0] == 6'd8) m_irq = data[0];
            else if (addr[5:0] == 6'd0 || addr[5:0] == 6'd4)
                m_word[addr[2]] = (m_word[addr[2]] & ~mask) | (data & mask);
        end else if (addr[10] && addr[7:4] == tqv_periph_pkg::slot_byte_regs &&
                     addr[3:2] == 2'b00) begin
            m_byte[addr[1:0]] = data[7:0];
        end
    endtask

    task automatic bus_read(input string name, input logic [10:0] addr);
        logic [31:0] exp;
        logic        ok;
        exp = ref_read(addr);
        @(posedge clk);
        i_addr   <= addr;
        i_read_n <= 2'b10;
        wait_ready(name, ok);
        if (ok) record(name, exp, o_rdata);
        @(posedge clk);
        i_read_n        <= 2'b11;
        i_read_complete <= 1'b1;
        @(posedge clk);
        i_read_complete <= 1'b0;
    endtask

    task automatic set_ui(input logic [7:0] v);
        @(posedge clk);
        i_ui_in <= v;
        m_ui = v;
    endtask

    // Pins and interrupt lines against the model
    task automatic check_pins(input string name);
        @(negedge clk);
        record(name, {24'h0, ref_pins()}, {24'h0, o_uo_out});
        record({name, "_irq"}, {18'h0, 11'h0, m_irq, 2'b00}, {18'h0, o_user_interrupts});
    endtask

    always @(negedge clk) begin
        while (act_q.size() > 0) begin
            c_name = name_q.pop_front();
            c_exp  = exp_q.pop_front();
            c_act  = act_q.pop_front();
            checks++;
            assert (c_act == c_exp)
            else begin
                errors++;
                $display("ERR %s expected %h actual %h", c_name, c_exp, c_act);
            end
        end
    end

    initial begin
        #(wd_cycles * period);
        $display("Watchdog: run did not finish within %0d cycles", wd_cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] held;
        logic        ok;
        logic [4:0]  sel;
        rst_n = 1'b0;
        i_ui_in = 8'h00;
        i_addr = '0;
        i_wdata = '0;
        i_write_n = 2'b11;
        i_read_n = 2'b11;
        i_read_complete = 1'b0;
        m_gpio = 8'h00;
        m_irq = 1'b0;
        m_ui = 8'h00;
        m_word[0] = '0;
        m_word[1] = '0;
        for (int i = 0; i < 8; i++) m_sel[i] = 5'h01;
        for (int i = 0; i < 4; i++) m_byte[i] = 8'h00;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        check_pins("reset");
        record("reset_ready", 32'h0, {31'h0, o_ready});

        // GPIO output register with the reset selects
        for (int i = 0; i < n_loop; i++) begin
            bus_write(user_addr(tqv_periph_pkg::slot_gpio, 6'd0), next_rand(), 2'b10);
            bus_read("gpio_out", user_addr(tqv_periph_pkg::slot_gpio, 6'd0));
            check_pins("gpio_pins");
        end
        for (int i = 0; i < n_loop; i++) begin
            r = next_rand();
            set_ui(r[7:0]);
            bus_read("gpio_in", user_addr(tqv_periph_pkg::slot_gpio, 6'd4));
        end

        // Pin routing over populated and empty slots
        for (int i = 0; i < n_route; i++) begin
            r = next_rand();
            bus_write(user_addr(tqv_periph_pkg::slot_gpio, 6'd0), r, 2'b10);
            bus_write(user_addr(tqv_periph_pkg::slot_word_regs, 6'd0), next_rand(), 2'b10);
            bus_write(simple_addr(tqv_periph_pkg::slot_byte_regs, 4'd0), r >> 8, 2'b00);
            bus_write(simple_addr(tqv_periph_pkg::slot_byte_regs, 4'd1), r >> 16, 2'b00);
            for (int n = 0; n < 8; n++) begin
                r = next_rand();
                case (r[1:0])
                    2'd0:    sel = {1'b0, tqv_periph_pkg::slot_gpio};
                    2'd1:    sel = {1'b0, tqv_periph_pkg::slot_word_regs};
                    2'd2:    sel = {1'b1, tqv_periph_pkg::slot_byte_regs};
                    default: sel = r[12:8];
                endcase
                bus_write(sel_addr(3'(n)), {27'h0, sel}, 2'b10);
                bus_read("func_sel", sel_addr(3'(n)));
            end
            check_pins("pin_route");
        end

        // Sized writes into the word registers, then the interrupt flag
        for (int i = 0; i < n_loop; i++) begin
            r = next_rand();
            sel = {3'b000, r[1:0] == 2'b11 ? 2'b10 : r[1:0]};
            bus_write(user_addr(tqv_periph_pkg::slot_word_regs, {3'b0, r[2], 2'b00}),
                      next_rand(), sel[1:0]);
            bus_read("sized_write", user_addr(tqv_periph_pkg::slot_word_regs, {3'b0, r[2], 2'b00}));
        end
        bus_write(user_addr(tqv_periph_pkg::slot_word_regs, 6'd8), 32'h1, 2'b10);
        check_pins("irq_set");
        bus_read("irq_flag", user_addr(tqv_periph_pkg::slot_word_regs, 6'd8));
        bus_write(user_addr(tqv_periph_pkg::slot_word_regs, 6'd8), 32'h2, 2'b00);
        check_pins("irq_clear");

        // Simple region and empty slots
        for (int off = 0; off < 4; off++)
            bus_write(simple_addr(tqv_periph_pkg::slot_byte_regs, 4'(off)), next_rand(), 2'b00);
        for (int off = 0; off < 16; off++)
            bus_read("byte_regs", simple_addr(tqv_periph_pkg::slot_byte_regs, 4'(off)));
        for (int s = 0; s < 16; s++) begin
            r = next_rand();
            if (4'(s) != tqv_periph_pkg::slot_byte_regs)
                bus_read("empty_simple", simple_addr(4'(s), r[3:0]));
            if (4'(s) != tqv_periph_pkg::slot_gpio && 4'(s) != tqv_periph_pkg::slot_word_regs)
                bus_read("empty_user", user_addr(4'(s), r[9:4]));
        end

        // Held read data ignores input changes until the read completes
        held = ref_read(user_addr(tqv_periph_pkg::slot_gpio, 6'd4));
        @(posedge clk);
        i_addr   <= user_addr(tqv_periph_pkg::slot_gpio, 6'd4);
        i_read_n <= 2'b10;
        wait_ready("read_hold", ok);
        record("read_hold", held, o_rdata);
        // Read request stays up, so the bridge sees repeated reads of the pins
        for (int k = 0; k < 6; k++) begin
            r = next_rand();
            set_ui(held[7:0] + 8'd1 + {1'b0, r[6:0]});
            @(negedge clk);
            record("read_hold", held, o_rdata);
        end
        @(posedge clk);
        i_read_n        <= 2'b11;
        i_read_complete <= 1'b1;
        @(posedge clk);
        i_read_complete <= 1'b0;
        bus_read("read_after_hold", user_addr(tqv_periph_pkg::slot_gpio, 6'd4));

        repeat (3) @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
hdl/tqv_bus_pkg.sv
hdl/tqv_periph_pkg.sv
hdl/peri_bus_if.sv
hdl/byte_bus_if.sv
hdl/tqv_bus_bridge.sv
hdl/tqv_gpio.sv
hdl/tqv_pin_mux.sv
hdl/tqv_word_regs.sv
hdl/tqv_byte_regs.sv
hdl/tqv_peripherals.sv
tb/tqv_peripherals_props.sv
tb/tb_tqv_peripherals.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run the testbench and take its verdict from the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_tqv_peripherals -f src.f || exit 1
sim_out=$(./obj_dir/Vtb_tqv_peripherals 2>&1)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "^TEST PASSED$" && exit 0 || exit 1
